//--- Makefile
# Verilator build and run of the memory check testbench

VERILATOR ?= verilator
TOP       ?= memcheck_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/mem_arbiter.sv
/*
 * Memory arbiter
 * Round-robin between the checker and host ports onto one
 * single-port memory command, read data routed back by tag
 */

`timescale 1ns/1ps

module mem_arbiter
  import memcheck_pkg::*;
(
  input  logic  axi_clk,
  input  logic  rst,
  // Checker port
  input  logic  chk_req,
  input  logic  chk_we,
  input  addr_t chk_addr,
  input  data_t chk_wdata,
  output logic  chk_gnt,
  output logic  chk_rvalid,
  output data_t chk_rdata,
  // Host port
  input  logic  host_req,
  input  logic  host_we,
  input  addr_t host_addr,
  input  data_t host_wdata,
  output logic  host_gnt,
  output logic  host_rvalid,
  output data_t host_rdata,
  // Memory command
  output logic  mem_en,
  output logic  mem_we,
  output addr_t mem_addr,
  output data_t mem_wdata,
  input  data_t mem_rdata
);

  logic prio_host;
  logic rd_pend;
  logic rd_tag_host;

  // Host wins a tie only when it holds the priority
  assign chk_gnt  = chk_req && (!host_req || !prio_host);
  assign host_gnt = host_req && (!chk_req || prio_host);

  assign mem_en    = chk_gnt || host_gnt;
  assign mem_we    = host_gnt ? host_we    : chk_we;
  assign mem_addr  = host_gnt ? host_addr  : chk_addr;
  assign mem_wdata = host_gnt ? host_wdata : chk_wdata;

  // Priority passes to the other peer after each grant
  always_ff @(posedge axi_clk) begin
    if (rst) begin
      prio_host   <= 1'b0;
      rd_pend     <= 1'b0;
      rd_tag_host <= 1'b0;
    end else begin
      if (chk_gnt)  prio_host <= 1'b1;
      if (host_gnt) prio_host <= 1'b0;
      rd_pend     <= mem_en && !mem_we;
      rd_tag_host <= host_gnt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read return one cycle after the granted read
  ////////////////////////////////////////////////////////////

  assign chk_rvalid  = rd_pend && !rd_tag_host;
  assign host_rvalid = rd_pend && rd_tag_host;
  assign chk_rdata   = mem_rdata;
  assign host_rdata  = mem_rdata;

endmodule

//--- source/mem_checker.sv
/*
 * Memory checker
 * Writes the address pattern over a window, reads it back and
 * compares each word. Reports pass and the first failing address.
 * A verify strobe runs the read-back pass only.
 */

`timescale 1ns/1ps

module mem_checker
  import memcheck_pkg::*;
#(
  parameter int WIN_FIRST = 16,
  parameter int WIN_LAST  = 1007
) (
  input  logic  axi_clk,
  input  logic  rst,
  input  logic  start,
  input  logic  verify_start,
  output logic  req,
  output logic  we,
  output addr_t addr,
  output data_t wdata,
  input  logic  gnt,
  input  logic  rvalid,
  input  data_t rdata,
  output logic  busy,
  output logic  done,
  output logic  pass,
  output addr_t fail_addr
);

  check_state_t state;
  addr_t        cur_addr;
  logic         issue_done;
  logic         last_cmd;
  logic         push;
  logic         pop;
  logic         mismatch;

  // Two entries of issued read addresses cover back-to-back reads
  addr_t        q_addr [2];
  logic         q_wr_ptr;
  logic         q_rd_ptr;
  addr_t        q_head;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  assign req   = (state == WRITE) || ((state == READ) && !issue_done);
  assign we    = (state == WRITE);
  assign addr  = cur_addr;
  assign wdata = pattern_word(cur_addr);

  assign last_cmd = (cur_addr == addr_t'(WIN_LAST));

  assign busy = (state == WRITE) || (state == READ);
  assign done = (state == DONE);

  ////////////////////////////////////////////////////////////
  // Read return and compare
  ////////////////////////////////////////////////////////////

  assign push     = (state == READ) && req && gnt;
  assign pop      = (state == READ) && rvalid;
  assign q_head   = q_addr[q_rd_ptr];
  assign mismatch = pop && (rdata != pattern_word(q_head));

  always_ff @(posedge axi_clk) begin
    if (push) begin
      q_addr[q_wr_ptr] <= cur_addr;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
    end else begin
      if (push) q_wr_ptr <= ~q_wr_ptr;
      if (pop)  q_rd_ptr <= ~q_rd_ptr;
    end
  end

  // Only the first mismatch of a pass is kept
  always_ff @(posedge axi_clk) begin
    if (mismatch && pass) begin
      fail_addr <= q_head;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge axi_clk) begin
    if (rst) begin
      state      <= IDLE;
      cur_addr   <= addr_t'(WIN_FIRST);
      issue_done <= 1'b0;
      pass       <= 1'b0;
    end else begin
      case (state)
        IDLE, DONE: begin
          // Full test wins over a verify pass in the same cycle
          if (start) begin
            state      <= WRITE;
            cur_addr   <= addr_t'(WIN_FIRST);
            issue_done <= 1'b0;
            pass       <= 1'b1;
          end else if (verify_start) begin
            state      <= READ;
            cur_addr   <= addr_t'(WIN_FIRST);
            issue_done <= 1'b0;
            pass       <= 1'b1;
          end
        end
        WRITE: begin
          if (gnt) begin
            if (last_cmd) begin
              state    <= READ;
              cur_addr <= addr_t'(WIN_FIRST);
            end else begin
              cur_addr <= cur_addr + 1'b1;
            end
          end
        end
        READ: begin
          if (push) begin
            if (last_cmd) issue_done <= 1'b1;
            else          cur_addr   <= cur_addr + 1'b1;
          end
          if (mismatch) pass <= 1'b0;
          // Reads return in order so the last word closes the pass
          if (pop && (q_head == addr_t'(WIN_LAST))) state <= DONE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- source/memcheck_pkg.sv
/*
 * Memory check package
 * Word and address widths, their vector types, the checker FSM
 * states and the rule for the expected test pattern
 */

package memcheck_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // 32-bit words, 1024-word memory
  localparam int DATA_W = 32;
  localparam int ADDR_W = 10;

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [ADDR_W-1:0]   addr_t;

  // One half of a data word, used by the pattern rule
  typedef logic [DATA_W/2-1:0] half_t;

  ////////////////////////////////////////////////////////////
  // Checker FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } check_state_t;

  // Expected word for an address
  // Low half is the zero-extended address, high half its inverse
  function automatic data_t pattern_word(addr_t a);
    half_t lo;
    lo = half_t'(a);
    return {~lo, lo};
  endfunction

endpackage

//--- source/memcheck_top.sv
/*
 * Memory check top level
 * Start timer and checker test an on-chip SRAM that a host port
 * shares through a round-robin arbiter
 */

`timescale 1ns/1ps

module memcheck_top
  import memcheck_pkg::*;
#(
  parameter int START_DELAY = 1000,
  parameter int WIN_FIRST   = 16,
  parameter int WIN_LAST    = 1007
) (
  input  logic  axi_clk,
  input  logic  rst,
  input  logic  verify_start,
  input  logic  host_req,
  input  logic  host_we,
  input  addr_t host_addr,
  input  data_t host_wdata,
  output logic  host_gnt,
  output logic  host_rvalid,
  output data_t host_rdata,
  output logic  check_busy,
  output logic  check_done,
  output logic  check_pass,
  output addr_t check_fail_addr
);

  logic  check_start;

  // Checker request channel
  logic  chk_req;
  logic  chk_we;
  addr_t chk_addr;
  data_t chk_wdata;
  logic  chk_gnt;
  logic  chk_rvalid;
  data_t chk_rdata;

  // Memory command
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  data_t mem_rdata;

  ////////////////////////////////////////////////////////////
  // Memory test
  ////////////////////////////////////////////////////////////

  start_timer #(
    .START_DELAY(START_DELAY)
  ) timer_0 (
    .axi_clk(axi_clk),
    .rst(rst),
    .start(check_start)
  );

  mem_checker #(
    .WIN_FIRST(WIN_FIRST),
    .WIN_LAST(WIN_LAST)
  ) checker_0 (
    .axi_clk(axi_clk),
    .rst(rst),
    .start(check_start),
    .verify_start(verify_start),
    .req(chk_req),
    .we(chk_we),
    .addr(chk_addr),
    .wdata(chk_wdata),
    .gnt(chk_gnt),
    .rvalid(chk_rvalid),
    .rdata(chk_rdata),
    .busy(check_busy),
    .done(check_done),
    .pass(check_pass),
    .fail_addr(check_fail_addr)
  );

  ////////////////////////////////////////////////////////////
  // Shared memory
  ////////////////////////////////////////////////////////////

  mem_arbiter arbiter_0 (
    .axi_clk(axi_clk),
    .rst(rst),
    .chk_req(chk_req),
    .chk_we(chk_we),
    .chk_addr(chk_addr),
    .chk_wdata(chk_wdata),
    .chk_gnt(chk_gnt),
    .chk_rvalid(chk_rvalid),
    .chk_rdata(chk_rdata),
    .host_req(host_req),
    .host_we(host_we),
    .host_addr(host_addr),
    .host_wdata(host_wdata),
    .host_gnt(host_gnt),
    .host_rvalid(host_rvalid),
    .host_rdata(host_rdata),
    .mem_en(mem_en),
    .mem_we(mem_we),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

  sram_bank sram_0 (
    .axi_clk(axi_clk),
    .mem_en(mem_en),
    .mem_we(mem_we),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

endmodule

//--- source/sram_bank.sv
/*
 * SRAM bank
 * Single-port word memory, synchronous write, registered read
 */

`timescale 1ns/1ps

module sram_bank
  import memcheck_pkg::*;
(
  input  logic  axi_clk,
  input  logic  mem_en,
  input  logic  mem_we,
  input  addr_t mem_addr,
  input  data_t mem_wdata,
  output data_t mem_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  // Contents start unknown
  data_t mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // Access port
  ////////////////////////////////////////////////////////////

  // Read data valid in the cycle after the read command
  always_ff @(posedge axi_clk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        mem_rdata <= mem[mem_addr];
      end
    end
  end

endmodule

//--- source/start_timer.sv
/*
 * Start timer
 * Waits START_DELAY cycles after reset, then gives one start strobe
 */

`timescale 1ns/1ps

module start_timer #(
  parameter int START_DELAY = 1000
) (
  input  logic axi_clk,
  input  logic rst,
  output logic start
);

  localparam int CNT_W = $clog2(START_DELAY + 1);

  logic [CNT_W-1:0] count;
  logic             fired;

  // Down-counter that stops for good once the strobe has gone out
  always_ff @(posedge axi_clk) begin
    if (rst) begin
      count <= CNT_W'(START_DELAY - 1);
      fired <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      if (!fired) begin
        if (count == '0) begin
          start <= 1'b1;
          fired <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

//--- src.f
source/memcheck_pkg.sv
source/start_timer.sv
source/mem_checker.sv
source/mem_arbiter.sv
source/sram_bank.sv
source/memcheck_top.sv
verification/tb_clkgen.sv
verification/memcheck_chk.sv
verification/memcheck_tb.sv

//--- verification/memcheck_chk.sv
/*
 * Protocol assertions
 * Grant exclusion and read return timing at the arbiter ports,
 * busy and done exclusion at the checker
 */

`timescale 1ns/1ps

module memcheck_chk (
  input logic axi_clk,
  input logic rst,
  input logic chk_gnt,
  input logic chk_we,
  input logic chk_rvalid,
  input logic host_gnt,
  input logic host_we,
  input logic host_rvalid,
  input logic busy,
  input logic done
);

  // Number of failed assertions
  int assert_fails;

  initial assert_fails = 0;

  grant_exclusive: assert property (@(posedge axi_clk) disable iff (rst)
    !(chk_gnt && host_gnt))
    else begin $error("both peers granted in one cycle"); assert_fails++; end

  chk_read_return: assert property (@(posedge axi_clk) disable iff (rst)
    (chk_gnt && !chk_we) |=> chk_rvalid)
    else begin $error("checker read data missing"); assert_fails++; end

  chk_read_origin: assert property (@(posedge axi_clk) disable iff (rst)
    chk_rvalid |-> $past(chk_gnt && !chk_we))
    else begin $error("checker rvalid without a read"); assert_fails++; end

  host_read_return: assert property (@(posedge axi_clk) disable iff (rst)
    (host_gnt && !host_we) |=> host_rvalid)
    else begin $error("host read data missing"); assert_fails++; end

  host_read_origin: assert property (@(posedge axi_clk) disable iff (rst)
    host_rvalid |-> $past(host_gnt && !host_we))
    else begin $error("host rvalid without a read"); assert_fails++; end

  busy_done_exclusive: assert property (@(posedge axi_clk) disable iff (rst)
    !(busy && done))
    else begin $error("checker busy and done together"); assert_fails++; end

endmodule

// Arbiter and checker nets meet in the top level
bind memcheck_top memcheck_chk chk0 (
  .axi_clk(axi_clk),
  .rst(rst),
  .chk_gnt(chk_gnt),
  .chk_we(chk_we),
  .chk_rvalid(chk_rvalid),
  .host_gnt(host_gnt),
  .host_we(host_we),
  .host_rvalid(host_rvalid),
  .busy(check_busy),
  .done(check_done)
);

//--- verification/memcheck_tb.sv
/*
 * Memory check testbench
 * Directed tests of the start timer, the checker and the host port
 * of the shared memory, with a watchdog and a closing summary
 */

`timescale 1ns/1ps

module memcheck_tb
  import memcheck_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int START_DELAY  = 50;
  localparam int WIN_FIRST    = 8;
  localparam int WIN_LAST     = 71;
  localparam int SEED         = 32'h7d06479e;
  localparam int SETTLE_NS    = 2;
  localparam int GNT_LIMIT    = 8;
  localparam int HOST_WORDS   = 8;
  localparam int NUM_TESTS    = 5;
  // One test fits a full write and read pass plus host traffic
  localparam int WIN_LEN      = WIN_LAST - WIN_FIRST + 1;
  localparam int DONE_LIMIT   = 4 * WIN_LEN + 32;
  localparam int TEST_CYCLES  = 6 * WIN_LEN + 64;
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + START_DELAY + NUM_TESTS * TEST_CYCLES);

  logic  axi_clk;
  logic  rst;
  logic  verify_start;
  logic  host_req;
  logic  host_we;
  addr_t host_addr;
  data_t host_wdata;
  logic  host_gnt;
  logic  host_rvalid;
  data_t host_rdata;
  logic  check_busy;
  logic  check_done;
  logic  check_pass;
  addr_t check_fail_addr;

  int    error_count;
  int    check_count;
  int    tests_failed;
  int    errors_at_test_start;
  int    total_errors;
  // Host-written words outside the window
  data_t shadow [2**ADDR_W];
  bit    written [2**ADDR_W];
  addr_t written_q [$];
  addr_t bad_first;
  addr_t bad_second;

  tb_clkgen #(
    .PERIOD_NS(CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) clkgen0 (
    .axi_clk(axi_clk),
    .rst(rst)
  );

  memcheck_top #(
    .START_DELAY(START_DELAY),
    .WIN_FIRST(WIN_FIRST),
    .WIN_LAST(WIN_LAST)
  ) dut0 (
    .axi_clk(axi_clk),
    .rst(rst),
    .verify_start(verify_start),
    .host_req(host_req),
    .host_we(host_we),
    .host_addr(host_addr),
    .host_wdata(host_wdata),
    .host_gnt(host_gnt),
    .host_rvalid(host_rvalid),
    .host_rdata(host_rdata),
    .check_busy(check_busy),
    .check_done(check_done),
    .check_pass(check_pass),
    .check_fail_addr(check_fail_addr)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Address in the low half, its inverse in the high half
  function automatic data_t expected_word(addr_t a);
    logic [DATA_W/2-1:0] low;
    low = '0;
    low[ADDR_W-1:0] = a;
    return {~low, low};
  endfunction

  function automatic addr_t random_outside_addr();
    int r;
    r = $urandom_range(2**ADDR_W - 1, 0);
    while (r >= WIN_FIRST && r <= WIN_LAST) begin
      r = $urandom_range(2**ADDR_W - 1, 0);
    end
    return addr_t'(r);
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("Check failed: %s", what);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_count - errors_at_test_start;
    if (errs != 0) tests_failed++;
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    errors_at_test_start = error_count;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!check_done && cycles < DONE_LIMIT) begin
      @(negedge axi_clk);
      cycles++;
    end
    check_true(check_done, $sformatf("check_done did not rise within %0d cycles", DONE_LIMIT));
  endtask

  task automatic pulse_verify();
    verify_start = 1'b1;
    @(negedge axi_clk);
    verify_start = 1'b0;
    check_value("check_busy", check_busy, 1);
  endtask

  // Called on a falling edge; the grant is sampled once it has settled
  task automatic host_access(input logic we, input addr_t a, input data_t wd,
                             output data_t rd, output int waits);
    logic granted;
    granted = 1'b0;
    waits = 0;
    rd = '0;
    host_req = 1'b1;
    host_we = we;
    host_addr = a;
    host_wdata = wd;
    while (!granted && waits < GNT_LIMIT) begin
      #(SETTLE_NS);
      if (host_gnt) begin
        granted = 1'b1;
      end else begin
        @(negedge axi_clk);
        waits++;
      end
    end
    check_true(granted, $sformatf("host request to 0x%0h was never granted", a));
    if (granted) begin
      @(negedge axi_clk);
      if (!we) begin
        check_value("host_rvalid", host_rvalid, 1);
        rd = host_rdata;
      end
    end
    host_req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_and_first_pass();
    int cycles;
    check_value("check_busy", check_busy, 0);
    check_value("check_done", check_done, 0);
    check_value("check_pass", check_pass, 0);
    check_value("host_gnt", host_gnt, 0);
    check_value("host_rvalid", host_rvalid, 0);
    cycles = 0;
    while (!check_busy && cycles <= START_DELAY + 8) begin
      @(negedge axi_clk);
      cycles++;
    end
    check_true(cycles == START_DELAY + 1, $sformatf(
      "check_busy rose %0d cycles after reset, expected %0d", cycles, START_DELAY + 1));
    wait_done();
    check_value("check_pass", check_pass, 1);
    finish_test("reset and first pass");
  endtask

  task automatic host_write_read();
    int    i;
    int    waits;
    addr_t a;
    data_t d;
    data_t rd;
    for (i = 0; i < HOST_WORDS; i++) begin
      a = random_outside_addr();
      d = $urandom;
      host_access(1'b1, a, d, rd, waits);
      check_true(waits == 0, "idle host write was not granted at once");
      if (!written[a]) written_q.push_back(a);
      written[a] = 1'b1;
      shadow[a] = d;
    end
    for (i = 0; i < written_q.size(); i++) begin
      a = written_q[i];
      host_access(1'b0, a, '0, rd, waits);
      check_value($sformatf("host_rdata @0x%0h", a), rd, shadow[a]);
    end
    finish_test("host write and read");
  endtask

  task automatic scan_window();
    int    i;
    int    waits;
    addr_t a;
    data_t rd;
    for (i = WIN_FIRST; i <= WIN_LAST; i++) begin
      a = addr_t'(i);
      host_access(1'b0, a, '0, rd, waits);
      check_value($sformatf("host_rdata @0x%0h", a), rd, expected_word(a));
    end
    finish_test("window contents");
  endtask

  task automatic detect_corruption();
    int    off;
    int    waits;
    data_t rd;
    // First address leaves room for a higher one
    off = $urandom_range(WIN_LAST - WIN_FIRST - 1, 0);
    bad_first = addr_t'(WIN_FIRST + off);
    off = $urandom_range(WIN_LAST - WIN_FIRST - off - 1, 0);
    bad_second = addr_t'(int'(bad_first) + 1 + off);
    host_access(1'b1, bad_first, expected_word(bad_first) ^ (data_t'($urandom) | 32'h1),
                rd, waits);
    pulse_verify();
    wait_done();
    check_value("check_pass", check_pass, 0);
    check_value("check_fail_addr", check_fail_addr, bad_first);
    host_access(1'b1, bad_second, expected_word(bad_second) ^ (data_t'($urandom) | 32'h1),
                rd, waits);
    pulse_verify();
    wait_done();
    check_value("check_pass", check_pass, 0);
    check_value("check_fail_addr", check_fail_addr, bad_first);
    finish_test("corruption detection");
  endtask

  task automatic contend_with_checker();
    int    reads;
    int    waits;
    addr_t a;
    data_t rd;
    host_access(1'b1, bad_first, expected_word(bad_first), rd, waits);
    host_access(1'b1, bad_second, expected_word(bad_second), rd, waits);
    pulse_verify();
    reads = 0;
    while (check_busy) begin
      a = written_q[$urandom_range(written_q.size() - 1, 0)];
      host_access(1'b0, a, '0, rd, waits);
      check_true(waits < 2, $sformatf("host read of 0x%0h waited %0d cycles", a, waits));
      check_value($sformatf("host_rdata @0x%0h", a), rd, shadow[a]);
      reads++;
    end
    check_true(reads > 0, "no host read overlapped the verify pass");
    wait_done();
    check_value("check_pass", check_pass, 1);
    finish_test("contention");
  endtask

  ////////////////////////////////////////////////////////////
  // Run
  ////////////////////////////////////////////////////////////

  initial begin
    verify_start = 1'b0;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    error_count = 0;
    check_count = 0;
    tests_failed = 0;
    errors_at_test_start = 0;
    void'($urandom(SEED));
    @(negedge rst);
    reset_and_first_pass();
    host_write_read();
    scan_window();
    detect_corruption();
    contend_with_checker();
    total_errors = error_count + dut0.chk0.assert_fails;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             NUM_TESTS, tests_failed, check_count, error_count, dut0.chk0.assert_fails);
    if (total_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- verification/tb_clkgen.sv
/*
 * Testbench clock and reset
 * Free-running clock and a reset held for a fixed number of cycles
 */

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic axi_clk,
  output logic rst
);

  initial axi_clk = 1'b0;

  always #(PERIOD_NS / 2) axi_clk = ~axi_clk;

  // Reset drops on a falling edge like the other stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge axi_clk);
    @(negedge axi_clk);
    rst = 1'b0;
  end

endmodule
